/* bench/ft_fifo_model.sv */
// behavioral usb fifo chip, pins sampled and driven on the falling clock edge
// host bytes enter on a rising edge strobe, txe follows tx_en_i directly
`timescale 1ns/1ns
`default_nettype none

module ft_fifo_model (
  input  logic           clk_i,
  // host side, bytes waiting to go to the bridge
  input  logic           host_push_i,
  input  pti_pkg::byte_t host_byte_i,
  input  logic           tx_en_i,
  // chip pins, seen from the chip
  input  logic           rd_ni,
  input  logic           wr_ni,
  input  logic           oe_ni,
  input  pti_pkg::byte_t bus_i,
  output logic           rxf_no,
  output logic           txe_no,
  output pti_pkg::byte_t bus_o,
  // one pulse per byte taken from the bridge
  output logic           got_o,
  output pti_pkg::byte_t got_byte_o,
  output logic [15:0]    rec_count_o
);

  pti_pkg::byte_t host_q[$];
  pti_pkg::byte_t rec_q[$];
  logic           rd_seen;

  initial begin
    rxf_no      = 1'b1;
    bus_o       = '0;
    got_o       = 1'b0;
    got_byte_o  = '0;
    rec_count_o = '0;
    rd_seen     = 1'b1;
  end

  // chip accepts bytes only while the host side allows it
  assign txe_no = !tx_en_i;

  // host queue fill
  always @(posedge clk_i) begin
    if (host_push_i) begin
      host_q.push_back(host_byte_i);
    end
  end

  // ====================
  // pin behavior
  // ====================
  always @(negedge clk_i) begin
    got_o <= 1'b0;
    // wr strobe low, data is on the bus
    if (!wr_ni) begin
      rec_q.push_back(bus_i);
      got_o      <= 1'b1;
      got_byte_o <= bus_i;
    end
    // rd released, head byte has been taken
    if (!rd_seen && rd_ni && host_q.size() > 0) begin
      host_q.pop_front();
    end
    rd_seen     <= rd_ni;
    rxf_no      <= (host_q.size() == 0);
    // head shows only while the output enable is low
    bus_o       <= (!oe_ni && host_q.size() > 0) ? host_q[0] : 8'h00;
    rec_count_o <= 16'(rec_q.size());
  end

endmodule

`default_nettype wire

/* bench/tb_pti.sv */
// drives the bridge from the bus and the chip model, inputs change on the falling edge
// every wait is bounded, errors are counted and summed up at the end
`timescale 1ns/1ns
`default_nettype none

module tb_pti;

  localparam int RX_DEPTH  = 16;
  localparam int TX_DEPTH  = 4;
  localparam int ACK_LIMIT = 400;
  localparam int ST_W      = $bits(pti_pkg::status_t);

  logic           wb_clk_i = 1'b0;
  logic           rst_i;
  // chip pins
  logic           rxf_n;
  logic           txe_n;
  pti_pkg::byte_t chip_dat;
  logic           rd_n;
  logic           wr_n;
  logic           oe_n;
  logic           siwu_n;
  pti_pkg::byte_t port_dat;
  // wishbone
  logic           cs;
  logic           cyc;
  logic           stb;
  logic           we;
  logic [4:0]     adr;
  pti_pkg::word_t wdat;
  logic           ack;
  pti_pkg::word_t rdat;
  // chip model control and record
  logic           host_push;
  pti_pkg::byte_t host_byte;
  logic           tx_en;
  logic           got;
  pti_pkg::byte_t got_byte;
  logic [15:0]    rec_count;

  // reference queues
  pti_pkg::byte_t exp_rx_q[$];
  pti_pkg::byte_t exp_tx_q[$];
  pti_pkg::byte_t tx_head;
  int             errors;
  int             sent_total;
  logic [31:0]    lcg_state;
  string          cur_test;

  always #4 wb_clk_i = ~wb_clk_i;

  pti_top #(
    .RX_DEPTH(RX_DEPTH),
    .TX_DEPTH(TX_DEPTH)
  ) pti_top_i (
    .wb_clk_i(wb_clk_i),
    .rst_i   (rst_i),
    .rxf_ni  (rxf_n),
    .txe_ni  (txe_n),
    .dat_i   (chip_dat),
    .rd_no   (rd_n),
    .wr_no   (wr_n),
    .oe_no   (oe_n),
    .siwu_no (siwu_n),
    .dat_o   (port_dat),
    .cs_i    (cs),
    .wb_cyc_i(cyc),
    .wb_stb_i(stb),
    .wb_we_i (we),
    .wb_adr_i(adr),
    .wb_dat_i(wdat),
    .wb_ack_o(ack),
    .wb_dat_o(rdat)
  );

  ft_fifo_model u_chip (
    .clk_i      (wb_clk_i),
    .host_push_i(host_push),
    .host_byte_i(host_byte),
    .tx_en_i    (tx_en),
    .rd_ni      (rd_n),
    .wr_ni      (wr_n),
    .oe_ni      (oe_n),
    .bus_i      (port_dat),
    .rxf_no     (rxf_n),
    .txe_no     (txe_n),
    .bus_o      (chip_dat),
    .got_o      (got),
    .got_byte_o (got_byte),
    .rec_count_o(rec_count)
  );

  // lcg, upper bits carry the useful randomness
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("ERR %s: expected %0h, got %0h", cur_test, exp, act);
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("%s: %s", cur_test, what);
  endtask

  // ====================
  // bus access
  // ====================
  task automatic bus_issue(input logic wr, input logic [1:0] sel, input pti_pkg::word_t data);
    @(negedge wb_clk_i);
    cs   = 1'b1;
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = wr;
    adr  = {sel, 3'b000};
    wdat = data;
  endtask

  // returns on the falling edge where ack is seen
  task automatic wait_ack(input int limit, output logic acked);
    acked = 1'b0;
    for (int i = 0; i < limit && !acked; i++) begin
      @(negedge wb_clk_i);
      if (ack) begin
        acked = 1'b1;
      end
    end
  endtask

  // stb low for one full clock so the slave rearms
  task automatic bus_release();
    cs  = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge wb_clk_i);
  endtask

  task automatic bus_read(input logic [1:0] sel, output pti_pkg::word_t data);
    logic acked;
    bus_issue(1'b0, sel, '0);
    wait_ack(ACK_LIMIT, acked);
    data = rdat;
    if (!acked) begin
      report_fault("bus read got no ack before the timeout");
    end
    bus_release();
  endtask

  // word goes out as eight bytes, low byte first
  task automatic queue_word(input pti_pkg::word_t data);
    for (int b = 0; b < 8; b++) begin
      exp_tx_q.push_back(data[8*b +: 8]);
    end
    sent_total += 8;
  endtask

  task automatic bus_write(input pti_pkg::word_t data);
    logic acked;
    bus_issue(1'b1, 2'b00, data);
    queue_word(data);
    wait_ack(ACK_LIMIT, acked);
    if (!acked) begin
      report_fault("bus write got no ack before the timeout");
    end
    bus_release();
  endtask

  task automatic host_send(input pti_pkg::byte_t b);
    @(negedge wb_clk_i);
    host_push = 1'b1;
    host_byte = b;
    exp_rx_q.push_back(b);
    @(negedge wb_clk_i);
    host_push = 1'b0;
  endtask

  // ====================
  // rx side checks
  // ====================
  // fifo holds what the host sent, up to its depth
  task automatic wait_rx_count();
    pti_pkg::word_t cnt;
    int             want;
    want = (exp_rx_q.size() < RX_DEPTH) ? exp_rx_q.size() : RX_DEPTH;
    cnt  = '1;
    for (int i = 0; i < 100 && cnt != 64'(want); i++) begin
      bus_read(pti_pkg::REG_RX_COUNT, cnt);
    end
    if (cnt != 64'(want)) begin
      report_mismatch(64'(want), cnt);
    end
  endtask

  task automatic pop_rx_byte();
    pti_pkg::word_t d;
    pti_pkg::byte_t e;
    wait_rx_count();
    bus_read(pti_pkg::REG_RX_DATA, d);
    e = exp_rx_q.pop_front();
    if (d != 64'(e)) begin
      report_mismatch(64'(e), d);
    end
  endtask

  // pop only when status says a byte is there
  task automatic try_pop_rx();
    pti_pkg::word_t   d;
    pti_pkg::status_t st;
    pti_pkg::byte_t   e;
    bus_read(pti_pkg::REG_STATUS, d);
    st = d[ST_W-1:0];
    if (!st.rx_empty) begin
      bus_read(pti_pkg::REG_RX_DATA, d);
      if (exp_rx_q.size() == 0) begin
        report_fault("rx byte popped that the host never sent");
      end else begin
        e = exp_rx_q.pop_front();
        if (d != 64'(e)) begin
          report_mismatch(64'(e), d);
        end
      end
    end
  endtask

  // tx fifo empty, serializer idle, every byte seen by the chip
  task automatic wait_tx_drain();
    pti_pkg::word_t   d;
    pti_pkg::status_t st;
    logic             idle;
    idle = 1'b0;
    for (int i = 0; i < 300 && !idle; i++) begin
      bus_read(pti_pkg::REG_STATUS, d);
      st   = d[ST_W-1:0];
      idle = (st.tx_count == '0) && !st.tx_busy && (exp_tx_q.size() == 0);
    end
    if (!idle) begin
      report_fault("tx path did not drain before the timeout");
    end
  endtask

  // each byte at the chip against the head of the expected queue
  always @(posedge wb_clk_i) begin
    if (got) begin
      if (exp_tx_q.size() == 0) begin
        report_fault("chip got a byte that was never written");
      end else begin
        tx_head = exp_tx_q.pop_front();
        if (got_byte != tx_head) begin
          report_mismatch(64'(tx_head), 64'(got_byte));
        end
      end
    end
  end

  // ====================
  // test sequence
  // ====================
  initial begin
    pti_pkg::word_t   d;
    logic [31:0]      r;
    logic             acked;
    logic [15:0]      rec_before;

    errors     = 0;
    sent_total = 0;
    lcg_state  = 32'd91;
    cur_test   = "reset";
    rst_i      = 1'b1;
    cs         = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    wdat       = '0;
    host_push  = 1'b0;
    host_byte  = '0;
    tx_en      = 1'b1;
    repeat (10) @(negedge wb_clk_i);
    rst_i = 1'b0;
    @(negedge wb_clk_i);

    // idle pins, no ack, empty fifos
    if ({rd_n, wr_n, oe_n, siwu_n} != 4'hf) begin
      report_mismatch(64'hf, 64'({rd_n, wr_n, oe_n, siwu_n}));
    end
    if (ack != 1'b0) begin
      report_mismatch(64'h0, 64'(ack));
    end
    // counts zero, only rx_empty set, it sits above tx_full and tx_busy
    bus_read(pti_pkg::REG_STATUS, d);
    if (d != 64'h4) begin
      report_mismatch(64'h4, d);
    end

    // host bytes read back in order
    cur_test = "rx_order";
    for (int i = 0; i < 20; i++) begin
      r = next_rand();
      host_send(r[23:16]);
    end
    for (int i = 0; i < 20; i++) begin
      pop_rx_byte();
    end

    // written words reach the chip low byte first
    cur_test = "tx_order";
    for (int i = 0; i < 6; i++) begin
      bus_write({next_rand(), next_rand()});
    end
    wait_tx_drain();

    // one word sits in the shift register, so capacity is the fifo plus one
    cur_test = "tx_backpressure";
    tx_en    = 1'b0;
    for (int i = 0; i < TX_DEPTH + 1; i++) begin
      bus_write({next_rand(), next_rand()});
    end
    rec_before = rec_count;
    r          = next_rand();
    bus_issue(1'b1, 2'b00, {r, next_rand()});
    queue_word({r, lcg_state});
    wait_ack(50, acked);
    if (acked) begin
      report_fault("write was acked while the tx path was full");
    end
    if (rec_count != rec_before) begin
      report_mismatch(64'(rec_before), 64'(rec_count));
    end
    tx_en = 1'b1;
    wait_ack(ACK_LIMIT, acked);
    if (!acked) begin
      report_fault("blocked write was never acked after txe went low");
    end
    bus_release();
    wait_tx_drain();

    // empty rx fifo reads as zero and is not popped
    cur_test = "rx_empty_read";
    bus_read(pti_pkg::REG_RX_DATA, d);
    if (d != '0) begin
      report_mismatch(64'h0, d);
    end
    bus_read(pti_pkg::REG_RX_COUNT, d);
    if (d != '0) begin
      report_mismatch(64'h0, d);
    end

    // both directions at once, txe dropping now and then
    cur_test = "mixed";
    for (int it = 0; it < 60; it++) begin
      r     = next_rand();
      tx_en = r[31] | r[30] | r[27];
      if (r[29:28] != 2'b00) begin
        host_send(r[23:16]);
      end
      if (r[27]) begin
        bus_write({next_rand(), next_rand()});
      end
      if (r[26:25] != 2'b00) begin
        try_pop_rx();
      end
      repeat (r[22:20]) @(negedge wb_clk_i);
    end
    tx_en = 1'b1;
    for (int i = 0; i < 400 && exp_rx_q.size() > 0; i++) begin
      try_pop_rx();
    end
    if (exp_rx_q.size() != 0) begin
      report_fault("host bytes never came out of the rx fifo");
    end
    wait_tx_drain();

    // total bytes the chip recorded
    cur_test = "tx_total";
    if (rec_count != 16'(sent_total)) begin
      report_mismatch(64'(sent_total), 64'(rec_count));
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds the bridge testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_pti -f tb.f -o tb_pti_sim

./obj_dir/tb_pti_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without failure"
exit 0

/* src/pti_fifo.sv */
// push only while not full and pop only while empty is low
// DEPTH must stay below 2**CNT_W
`timescale 1ns/1ns
`default_nettype none

module pti_fifo #(
  parameter type payload_t = pti_pkg::byte_t,
  parameter int  DEPTH     = 16
) (
  input  logic                     wb_clk_i,
  input  logic                     rst_i,
  input  logic                     push_i,
  input  payload_t                 push_data_i,
  input  logic                     pop_i,
  output payload_t                 pop_data_o,
  output logic [pti_pkg::CNT_W-1:0] count_o,
  output logic                     full_o,
  output logic                     empty_o
);

  // pointer width, at least one bit for a single entry
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // last slot index, pointers wrap after it
  localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);
  // occupancy value that means full
  localparam logic [pti_pkg::CNT_W-1:0] DEPTH_CNT = DEPTH[pti_pkg::CNT_W-1:0];

  // storage
  payload_t mem [0:DEPTH-1];

  logic [AW-1:0]             wr_ptr_q;
  logic [AW-1:0]             rd_ptr_q;
  logic [pti_pkg::CNT_W-1:0] count_q;

  // ====================
  // pointers and count
  // ====================
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // write port
  always_ff @(posedge wb_clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // head entry shows without a pop
  assign pop_data_o = mem[rd_ptr_q];

  assign count_o = count_q;
  assign full_o  = (count_q == DEPTH_CNT);
  assign empty_o = (count_q == '0);

  // ====================
  // checks
  // ====================
  // the pusher must watch full, the popper must watch empty
  a_no_push_full: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* src/pti_pkg.sv */
// types and register codes shared by the byte-wide USB FIFO bridge
// one clock domain only, the chip pins are sampled on wb_clk_i
`default_nettype none

package pti_pkg;

  // ====================
  // data types
  // ====================

  // one chip data byte
  typedef logic [7:0] byte_t;

  // one wishbone data word
  typedef logic [63:0] word_t;

  // width of every fifo occupancy count
  localparam int CNT_W = 16;

  // one wishbone request as seen by the slave, 72 bits
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    // only bits 4:3 are decoded
    logic [4:0] adr;
    word_t      dat;
  } wb_req_t;

  // status word at address 00, zero-extended onto the bus
  // tx_busy lands in bit 0, rx_count in the top field
  typedef struct packed {
    logic [CNT_W-1:0] rx_count;
    logic [CNT_W-1:0] tx_count;
    logic             rx_empty;
    logic             tx_full;
    logic             tx_busy;
  } status_t;

  // ====================
  // read address codes on adr[4:3]
  // ====================
  localparam logic [1:0] REG_STATUS   = 2'b00;
  localparam logic [1:0] REG_RX_COUNT = 2'b01;
  localparam logic [1:0] REG_RX_DATA  = 2'b10;

endpackage

`default_nettype wire

/* src/pti_port_ctrl.sv */
// receive wins over transmit; one rx byte spends four cycles off IDLE
// send-immediate is not used, siwu_no stays high
`timescale 1ns/1ns
`default_nettype none

module pti_port_ctrl (
  input  logic           wb_clk_i,
  input  logic           rst_i,
  // chip pins
  input  logic           rxf_ni,
  input  logic           txe_ni,
  input  pti_pkg::byte_t dat_i,
  output logic           rd_no,
  output logic           wr_no,
  output logic           oe_no,
  output logic           siwu_no,
  output pti_pkg::byte_t dat_o,
  // rx fifo write side
  output logic           rx_push_o,
  output pti_pkg::byte_t rx_data_o,
  input  logic           rx_full_i,
  // tx fifo read side
  output logic           tx_pop_o,
  input  pti_pkg::word_t tx_data_i,
  input  logic           tx_empty_i,
  output logic           tx_busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    RD_OE,
    RD_STROBE,
    RD_CAPTURE,
    OE_OFF,
    WR_STROBE
  } state_e;

  state_e         state_q;
  pti_pkg::word_t shift_q;
  logic [2:0]     byte_cnt_q;
  logic           tx_busy_q;
  logic           rx_req;
  logic           tx_load;

  // chip has data and there is room for it
  // rxf_ni is ignored while the rx fifo is full
  assign rx_req = !rxf_ni && !rx_full_i;

  // fetch the next word once the shift register is drained
  assign tx_load  = !tx_busy_q && !tx_empty_i;
  assign tx_pop_o = tx_load;

  assign tx_busy_o = tx_busy_q;
  // low byte of the shift register sits on the pins
  assign dat_o     = shift_q[7:0];
  assign siwu_no   = 1'b1;

  // ====================
  // pin sequencer
  // ====================
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      rd_no     <= 1'b1;
      wr_no     <= 1'b1;
      oe_no     <= 1'b1;
      rx_push_o <= 1'b0;
    end else begin
      // push is a single cycle strobe
      rx_push_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (rx_req) begin
            // chip drives the bus first
            oe_no   <= 1'b0;
            state_q <= RD_OE;
          end else if (tx_busy_q && !txe_ni) begin
            wr_no   <= 1'b0;
            state_q <= WR_STROBE;
          end
        end
        RD_OE: begin
          rd_no   <= 1'b0;
          state_q <= RD_STROBE;
        end
        RD_STROBE: begin
          // byte is valid now, release the strobe and push it
          rd_no     <= 1'b1;
          rx_push_o <= 1'b1;
          state_q   <= RD_CAPTURE;
        end
        RD_CAPTURE: begin
          oe_no   <= 1'b1;
          state_q <= OE_OFF;
        end
        OE_OFF: begin
          state_q <= IDLE;
        end
        WR_STROBE: begin
          // one low cycle per byte
          wr_no   <= 1'b1;
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // ====================
  // tx word serializer
  // ====================
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      tx_busy_q  <= 1'b0;
      byte_cnt_q <= '0;
    end else if (tx_load) begin
      tx_busy_q  <= 1'b1;
      byte_cnt_q <= '0;
    end else if (state_q == WR_STROBE) begin
      byte_cnt_q <= byte_cnt_q + 3'd1;
      // eighth byte done
      if (byte_cnt_q == 3'd7) begin
        tx_busy_q <= 1'b0;
      end
    end
  end

  // data registers, lsb goes out first
  always_ff @(posedge wb_clk_i) begin
    if (tx_load) begin
      shift_q <= tx_data_i;
    end else if (state_q == WR_STROBE) begin
      shift_q <= {8'h00, shift_q[63:8]};
    end
    if (state_q == RD_STROBE) begin
      rx_data_o <= dat_i;
    end
  end

  // ====================
  // checks
  // ====================
  // the chip never sees both strobes at once
  a_strobe_excl: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(!rd_no && !wr_no));

endmodule

`default_nettype wire

/* src/pti_top.sv */
// usb fifo chip to 64-bit wishbone bridge, all on wb_clk_i
// rx is byte per read, tx is eight bytes per written word, lsb first
`timescale 1ns/1ns
`default_nettype none

module pti_top #(
  parameter int RX_DEPTH = 16,
  parameter int TX_DEPTH = 4
) (
  input  logic           wb_clk_i,
  input  logic           rst_i,
  // chip side
  input  logic           rxf_ni,
  input  logic           txe_ni,
  input  pti_pkg::byte_t dat_i,
  output logic           rd_no,
  output logic           wr_no,
  output logic           oe_no,
  output logic           siwu_no,
  output pti_pkg::byte_t dat_o,
  // wishbone side
  input  logic           cs_i,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic [4:0]     wb_adr_i,
  input  pti_pkg::word_t wb_dat_i,
  output logic           wb_ack_o,
  output pti_pkg::word_t wb_dat_o
);

  // ====================
  // interconnect
  // ====================
  pti_pkg::wb_req_t          wb_req;

  // rx path, port controller to slave
  logic                      rx_push;
  pti_pkg::byte_t            rx_push_data;
  logic                      rx_pop;
  pti_pkg::byte_t            rx_pop_data;
  logic [pti_pkg::CNT_W-1:0] rx_count;
  logic                      rx_full;
  logic                      rx_empty;

  // tx path, slave to port controller
  logic                      tx_push;
  pti_pkg::word_t            tx_push_data;
  logic                      tx_pop;
  pti_pkg::word_t            tx_pop_data;
  logic [pti_pkg::CNT_W-1:0] tx_count;
  logic                      tx_full;
  logic                      tx_empty;
  logic                      tx_busy;

  // bus pins gathered into one request
  assign wb_req = '{
    cyc: wb_cyc_i,
    stb: wb_stb_i,
    we:  wb_we_i,
    adr: wb_adr_i,
    dat: wb_dat_i
  };

  pti_fifo #(
    .payload_t(pti_pkg::byte_t),
    .DEPTH    (RX_DEPTH)
  ) u_rx_fifo (
    .wb_clk_i   (wb_clk_i),
    .rst_i      (rst_i),
    .push_i     (rx_push),
    .push_data_i(rx_push_data),
    .pop_i      (rx_pop),
    .pop_data_o (rx_pop_data),
    .count_o    (rx_count),
    .full_o     (rx_full),
    .empty_o    (rx_empty)
  );

  pti_fifo #(
    .payload_t(pti_pkg::word_t),
    .DEPTH    (TX_DEPTH)
  ) u_tx_fifo (
    .wb_clk_i   (wb_clk_i),
    .rst_i      (rst_i),
    .push_i     (tx_push),
    .push_data_i(tx_push_data),
    .pop_i      (tx_pop),
    .pop_data_o (tx_pop_data),
    .count_o    (tx_count),
    .full_o     (tx_full),
    .empty_o    (tx_empty)
  );

  pti_port_ctrl u_port (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .rxf_ni    (rxf_ni),
    .txe_ni    (txe_ni),
    .dat_i     (dat_i),
    .rd_no     (rd_no),
    .wr_no     (wr_no),
    .oe_no     (oe_no),
    .siwu_no   (siwu_no),
    .dat_o     (dat_o),
    .rx_push_o (rx_push),
    .rx_data_o (rx_push_data),
    .rx_full_i (rx_full),
    .tx_pop_o  (tx_pop),
    .tx_data_i (tx_pop_data),
    .tx_empty_i(tx_empty),
    .tx_busy_o (tx_busy)
  );

  pti_wb_slave u_wb (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .cs_i      (cs_i),
    .wb_req_i  (wb_req),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .rx_pop_o  (rx_pop),
    .rx_data_i (rx_pop_data),
    .rx_count_i(rx_count),
    .rx_empty_i(rx_empty),
    .tx_push_o (tx_push),
    .tx_data_o (tx_push_data),
    .tx_count_i(tx_count),
    .tx_full_i (tx_full),
    .tx_busy_i (tx_busy)
  );

endmodule

`default_nettype wire

/* src/pti_wb_slave.sv */
// ack holds until stb drops; a write to a full tx fifo waits for space
// address 11 reads as zero
`timescale 1ns/1ns
`default_nettype none

module pti_wb_slave (
  input  logic                      wb_clk_i,
  input  logic                      rst_i,
  input  logic                      cs_i,
  input  pti_pkg::wb_req_t          wb_req_i,
  output logic                      wb_ack_o,
  output pti_pkg::word_t            wb_dat_o,
  // rx fifo read side
  output logic                      rx_pop_o,
  input  pti_pkg::byte_t            rx_data_i,
  input  logic [pti_pkg::CNT_W-1:0] rx_count_i,
  input  logic                      rx_empty_i,
  // tx fifo write side
  output logic                      tx_push_o,
  output pti_pkg::word_t            tx_data_o,
  input  logic [pti_pkg::CNT_W-1:0] tx_count_i,
  input  logic                      tx_full_i,
  input  logic                      tx_busy_i
);

  logic              active;
  logic              wr_done_q;
  logic              rd_done_q;
  logic              rd_accept;
  logic [1:0]        reg_sel;
  pti_pkg::status_t  status;
  pti_pkg::word_t    rd_word;

  // bus cycle addressed to us
  assign active  = cs_i && wb_req_i.cyc && wb_req_i.stb;
  assign reg_sel = wb_req_i.adr[4:3];

  // ====================
  // push and pop strobes
  // ====================
  // one push per bus cycle, retried while the fifo is full
  assign tx_push_o = active && wb_req_i.we && !wr_done_q && !tx_full_i;
  assign tx_data_o = wb_req_i.dat;

  // first clock of a read cycle
  assign rd_accept = active && !wb_req_i.we && !rd_done_q;
  // empty fifo is not popped
  assign rx_pop_o  = rd_accept && (reg_sel == pti_pkg::REG_RX_DATA) && !rx_empty_i;

  // ====================
  // read data
  // ====================
  assign status = '{
    rx_count: rx_count_i,
    tx_count: tx_count_i,
    rx_empty: rx_empty_i,
    tx_full:  tx_full_i,
    tx_busy:  tx_busy_i
  };

  always_comb begin
    case (reg_sel)
      pti_pkg::REG_STATUS:   rd_word = pti_pkg::word_t'(status);
      pti_pkg::REG_RX_COUNT: rd_word = pti_pkg::word_t'(rx_count_i);
      // head byte is the one being popped
      pti_pkg::REG_RX_DATA:  rd_word = rx_empty_i ? '0 : pti_pkg::word_t'(rx_data_i);
      default:               rd_word = '0;
    endcase
  end

  // ack and done flags
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wb_ack_o  <= 1'b0;
      wr_done_q <= 1'b0;
      rd_done_q <= 1'b0;
    end else if (!active) begin
      // cycle over, arm for the next one
      wb_ack_o  <= 1'b0;
      wr_done_q <= 1'b0;
      rd_done_q <= 1'b0;
    end else begin
      if (tx_push_o) begin
        wr_done_q <= 1'b1;
        wb_ack_o  <= 1'b1;
      end
      if (rd_accept) begin
        rd_done_q <= 1'b1;
        wb_ack_o  <= 1'b1;
      end
    end
  end

  // read data is sampled once, together with the rising ack
  always_ff @(posedge wb_clk_i) begin
    if (rd_accept) begin
      wb_dat_o <= rd_word;
    end
  end

  // ====================
  // checks
  // ====================
  // ack rises only in answer to a live request
  a_ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    $rose(wb_ack_o) |-> $past(active));

endmodule

`default_nettype wire

/* tb.f */
src/pti_pkg.sv
src/pti_fifo.sv
src/pti_port_ctrl.sv
src/pti_wb_slave.sv
src/pti_top.sv
bench/ft_fifo_model.sv
bench/tb_pti.sv
